// File: hw/qspinor_params.svh
`ifndef QSPINOR_PARAMS_SVH
`define QSPINOR_PARAMS_SVH

// flash address width seen on the bus
`define QSPINOR_ABW     24
`define QSPINOR_LANES   4  // io0..io3

// control space offsets
`define REG_CFG_OFS     3'd0
`define REG_STAT_OFS    3'd6

// config register fields
`define CFG_QUAD_BIT    0
`define CFG_DUMMY_LSB   4
`define CFG_DUMMY_MSB   7
`define CFG_CMD_LSB     8
`define CFG_CMD_MSB     15

// status register fields
`define STAT_BUSY_BIT   7

`define CMD_RESET_VAL   8'h03  // plain 1-1-1 read

`endif

// File: hw/qspinor_bus_pkg.sv
`include "qspinor_params.svh"

package qspinor_bus_pkg;

    typedef logic [31:0] bus_data_t;

    // byte address into flash space
    typedef logic [`QSPINOR_ABW-1:0] bus_addr_t;

    // control space offset, low bits of addr
    typedef logic [2:0] reg_ofs_t;

    typedef logic [1:0] acc_t;

    // access size codes
    parameter acc_t ACC_1B = 2'd0;
    parameter acc_t ACC_2B = 2'd1;
    parameter acc_t ACC_4B = 2'd2;

endpackage

// File: hw/qspinor_flash_pkg.sv
`include "qspinor_params.svh"

package qspinor_flash_pkg;

    // read sequence, one pass per bus read
    typedef enum logic [1:0] {
        IDLE,
        SEND,   // command + address out
        DUMMY,
        RECV    // data in
    } read_state_t;

    typedef logic [7:0] bit_idx_t;  // bit position or dummy cycles left

    typedef logic [7:0] flash_cmd_t;

    typedef logic [3:0] dummy_t;

    typedef logic [`QSPINOR_LANES-1:0] lanes_t;

endpackage

// File: hw/qspinor_regs.sv
`timescale 1ns/1ps
`include "qspinor_params.svh"

module qspinor_regs (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          req,
    input  logic                          wr_b,
    input  logic                          ctrl_sel,
    input  qspinor_bus_pkg::acc_t         acc,
    input  qspinor_bus_pkg::bus_addr_t    addr,
    input  qspinor_bus_pkg::bus_data_t    wdata,
    input  logic                          busy,
    input  logic                          done,
    input  qspinor_bus_pkg::bus_data_t    rx_word,
    output logic                          resp,
    output qspinor_bus_pkg::bus_data_t    rdata,
    output logic                          fault,
    output logic                          start,
    output logic                          quad_en,
    output qspinor_flash_pkg::dummy_t     dummy,
    output qspinor_flash_pkg::flash_cmd_t cmd,
    output qspinor_bus_pkg::bus_addr_t    read_addr,
    output qspinor_bus_pkg::acc_t         read_acc
);
    qspinor_bus_pkg::reg_ofs_t  ofs;
    qspinor_bus_pkg::bus_data_t cfg_word;
    qspinor_bus_pkg::bus_data_t stat_word;
    qspinor_bus_pkg::bus_data_t reg_rdata;
    logic                       is_cfg;
    logic                       is_stat;
    logic                       bad_wr;
    logic                       bad_ofs;
    logic                       bad_size;
    logic                       reg_ok;
    logic                       reg_resp;

    assign ofs     = addr[2:0];
    assign is_cfg  = (ofs == `REG_CFG_OFS);
    assign is_stat = (ofs == `REG_STAT_OFS);

    // flash space and status are read only
    assign bad_wr   = wr_b && (!ctrl_sel || is_stat);
    assign bad_ofs  = ctrl_sel && !is_cfg && !is_stat;
    assign bad_size = ctrl_sel && ((is_cfg && acc != qspinor_bus_pkg::ACC_2B) ||
                                   (is_stat && acc != qspinor_bus_pkg::ACC_1B));

    assign fault  = req && (bad_wr || bad_ofs || bad_size || busy);
    assign reg_ok = req && ctrl_sel && !fault;
    assign start  = req && !ctrl_sel && !fault;

    always_comb begin
        cfg_word = '0;
        cfg_word[`CFG_QUAD_BIT]                 = quad_en;
        cfg_word[`CFG_DUMMY_MSB:`CFG_DUMMY_LSB] = dummy;
        cfg_word[`CFG_CMD_MSB:`CFG_CMD_LSB]     = cmd;
        stat_word = '0;
        stat_word[`STAT_BUSY_BIT] = busy;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            quad_en <= 1'b0;
            dummy   <= '0;
            cmd     <= `CMD_RESET_VAL;
        end else if (reg_ok && wr_b && is_cfg) begin
            quad_en <= wdata[`CFG_QUAD_BIT];
            dummy   <= wdata[`CFG_DUMMY_MSB:`CFG_DUMMY_LSB];
            cmd     <= wdata[`CFG_CMD_MSB:`CFG_CMD_LSB];
        end
    end

    // register answers one cycle after req
    always_ff @(posedge clk) begin
        if (!rstn) begin
            reg_resp <= 1'b0;
        end else begin
            reg_resp <= reg_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_ok) begin
            reg_rdata <= wr_b ? '0 : (is_stat ? stat_word : cfg_word);
        end
    end

    // read target, held for the whole flash transfer
    always_ff @(posedge clk) begin
        if (start) begin
            read_addr <= addr;
            read_acc  <= acc;
        end
    end

    assign resp  = reg_resp | done;
    assign rdata = done ? rx_word : reg_rdata;

    a_resp_fault: assert property (@(posedge clk) disable iff (!rstn) !(resp && fault));

endmodule

// File: hw/qspinor_read_fsm.sv
`timescale 1ns/1ps

module qspinor_read_fsm (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           start,
    input  logic                           quad_en,
    input  qspinor_flash_pkg::dummy_t      dummy,
    input  qspinor_bus_pkg::acc_t          read_acc,
    input  logic                           cnt_zero,
    output logic                           busy,
    output logic                           done,
    output logic                           csb,
    output logic                           sck,
    output qspinor_flash_pkg::lanes_t      dir,
    output qspinor_flash_pkg::read_state_t state,
    output logic                           load,
    output qspinor_flash_pkg::bit_idx_t    load_val,
    output logic                           dec,
    output logic                           sample
);
    logic                        quad_q;
    qspinor_flash_pkg::dummy_t   dummy_q;
    qspinor_flash_pkg::bit_idx_t step;
    qspinor_flash_pkg::bit_idx_t data_bits;
    logic                        step_end;
    logic                        last_step;

    // quad_q is not valid yet in the start cycle
    assign step = ((state == qspinor_flash_pkg::IDLE) ? quad_en : quad_q) ? 8'd4 : 8'd1;

    always_comb begin
        case (read_acc)
            qspinor_bus_pkg::ACC_1B: data_bits = 8'd8;
            qspinor_bus_pkg::ACC_2B: data_bits = 8'd16;
            default:                 data_bits = 8'd32;
        endcase
    end

    assign step_end  = !csb && sck;  // second clock of a bit step
    assign last_step = step_end && cnt_zero;
    assign dec       = step_end && !cnt_zero;
    assign sample    = (state == qspinor_flash_pkg::RECV) && !sck;  // sck rises next edge
    assign busy      = !csb;

    always_comb begin
        load     = 1'b0;
        load_val = '0;
        case (state)
            qspinor_flash_pkg::IDLE: begin
                load     = start;
                load_val = 8'd32 - step;  // top bit of cmd+addr
            end
            qspinor_flash_pkg::SEND: begin
                load     = last_step;
                load_val = (dummy_q != '0) ? {4'd0, dummy_q} - 8'd1 : data_bits - step;
            end
            qspinor_flash_pkg::DUMMY: begin
                load     = last_step;
                load_val = data_bits - step;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quad_q  <= quad_en;
            dummy_q <= dummy;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= qspinor_flash_pkg::IDLE;
            csb   <= 1'b1;
            sck   <= 1'b0;
            dir   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                qspinor_flash_pkg::IDLE: begin
                    sck <= 1'b0;
                    if (start) begin
                        state <= qspinor_flash_pkg::SEND;
                        csb   <= 1'b0;
                        dir   <= quad_en ? 4'hf : 4'h1;
                    end
                end
                qspinor_flash_pkg::SEND: begin
                    sck <= ~sck;
                    if (last_step) begin
                        dir   <= '0;  // release for turnaround
                        state <= (dummy_q != '0) ? qspinor_flash_pkg::DUMMY
                                                 : qspinor_flash_pkg::RECV;
                    end
                end
                qspinor_flash_pkg::DUMMY: begin
                    sck <= ~sck;
                    if (last_step) begin
                        state <= qspinor_flash_pkg::RECV;
                    end
                end
                default: begin
                    sck <= ~sck;
                    if (last_step) begin
                        state <= qspinor_flash_pkg::IDLE;
                        csb   <= 1'b1;
                        done  <= 1'b1;
                    end
                end
            endcase
        end
    end

    a_sck_idle: assert property (@(posedge clk) disable iff (!rstn) csb |-> !sck);
    a_start_idle: assert property (@(posedge clk) disable iff (!rstn)
        start |-> state == qspinor_flash_pkg::IDLE);

endmodule

// File: hw/qspinor_bit_counter.sv
`timescale 1ns/1ps

module qspinor_bit_counter (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        load,
    input  qspinor_flash_pkg::bit_idx_t load_val,
    input  logic                        dec,
    input  logic                        quad,
    output qspinor_flash_pkg::bit_idx_t count,
    output logic                        cnt_zero
);
    qspinor_flash_pkg::bit_idx_t step;

    // four bits per step on all lanes, otherwise one
    assign step = quad ? 8'd4 : 8'd1;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
        end else if (load) begin
            count <= load_val;
        end else if (dec) begin
            count <= count - step;
        end
    end

    assign cnt_zero = (count == '0);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rstn) dec |-> count >= step);

endmodule

// File: hw/qspinor_shifter.sv
`timescale 1ns/1ps

module qspinor_shifter (
    input  logic                           clk,
    input  logic                           rstn,
    input  qspinor_flash_pkg::flash_cmd_t  cmd,
    input  qspinor_bus_pkg::bus_addr_t     read_addr,
    input  qspinor_bus_pkg::acc_t          read_acc,
    input  logic                           quad_en,
    input  qspinor_flash_pkg::bit_idx_t    count,
    input  logic                           sample,
    input  qspinor_flash_pkg::read_state_t state,
    input  qspinor_flash_pkg::lanes_t      lanes_in,
    output qspinor_flash_pkg::lanes_t      lanes_out,
    output qspinor_bus_pkg::bus_data_t     rx_word
);
    qspinor_bus_pkg::bus_data_t tx_word;
    logic [4:0]                 tx_pos;
    logic [4:0]                 rx_pos;
    logic [4:0]                 mirror;

    // outgoing frame, command then address
    assign tx_word = {cmd, read_addr};
    assign tx_pos  = quad_en ? {count[4:2], 2'b00} : count[4:0];

    always_comb begin
        lanes_out = '0;
        if (state == qspinor_flash_pkg::SEND) begin
            if (quad_en) begin
                lanes_out = tx_word[tx_pos +: 4];  // io3 carries the msb
            end else begin
                lanes_out[0] = tx_word[tx_pos];
            end
        end
    end

    // flip the byte index so the first byte lands in bits 7:0
    always_comb begin
        case (read_acc)
            qspinor_bus_pkg::ACC_1B: mirror = 5'd0;
            qspinor_bus_pkg::ACC_2B: mirror = 5'd8;
            default:                 mirror = 5'd24;
        endcase
    end

    assign rx_pos = count[4:0] ^ mirror;

    always_ff @(posedge clk) begin
        if (!rstn || state == qspinor_flash_pkg::IDLE) begin
            rx_word <= '0;
        end else if (sample && state == qspinor_flash_pkg::RECV) begin
            if (quad_en) begin
                rx_word[rx_pos +: 4] <= lanes_in;
            end else begin
                rx_word[rx_pos] <= lanes_in[1];  // single mode data on io1
            end
        end
    end

endmodule

// File: hw/qspinor_top.sv
`timescale 1ns/1ps
`include "qspinor_params.svh"

module qspinor_top (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       req,
    input  logic                       wr_b,
    input  logic                       ctrl_sel,  // 0 flash space, 1 registers
    input  qspinor_bus_pkg::acc_t      acc,
    input  qspinor_bus_pkg::bus_addr_t addr,
    input  qspinor_bus_pkg::bus_data_t wdata,
    output logic                       resp,
    output qspinor_bus_pkg::bus_data_t rdata,
    output logic                       fault,
    output logic                       qspi_sck,
    output logic                       qspi_csb,
    inout  wire qspinor_flash_pkg::lanes_t qspi_data
);
    logic                           busy;
    logic                           done;
    logic                           start;
    logic                           quad_en;
    qspinor_flash_pkg::dummy_t      dummy;
    qspinor_flash_pkg::flash_cmd_t  cmd;
    qspinor_bus_pkg::bus_addr_t     read_addr;
    qspinor_bus_pkg::acc_t          read_acc;
    qspinor_bus_pkg::bus_data_t     rx_word;
    qspinor_flash_pkg::read_state_t state;
    qspinor_flash_pkg::lanes_t      dir;
    qspinor_flash_pkg::lanes_t      lanes_out;
    qspinor_flash_pkg::lanes_t      lanes_in;
    qspinor_flash_pkg::bit_idx_t    load_val;
    qspinor_flash_pkg::bit_idx_t    count;
    logic                           load;
    logic                           dec;
    logic                           sample;
    logic                           cnt_zero;
    logic                           cnt_quad;

    // dummy cycles count one per sck even in quad mode
    assign cnt_quad = quad_en && (state != qspinor_flash_pkg::DUMMY);

    qspinor_regs u_regs (
        .clk(clk), .rstn(rstn), .req(req), .wr_b(wr_b), .ctrl_sel(ctrl_sel),
        .acc(acc), .addr(addr), .wdata(wdata), .busy(busy), .done(done),
        .rx_word(rx_word), .resp(resp), .rdata(rdata), .fault(fault), .start(start),
        .quad_en(quad_en), .dummy(dummy), .cmd(cmd), .read_addr(read_addr),
        .read_acc(read_acc)
    );

    qspinor_read_fsm u_fsm (
        .clk(clk), .rstn(rstn), .start(start), .quad_en(quad_en), .dummy(dummy),
        .read_acc(read_acc), .cnt_zero(cnt_zero), .busy(busy), .done(done),
        .csb(qspi_csb), .sck(qspi_sck), .dir(dir), .state(state), .load(load),
        .load_val(load_val), .dec(dec), .sample(sample)
    );

    qspinor_bit_counter u_cnt (
        .clk(clk), .rstn(rstn), .load(load), .load_val(load_val), .dec(dec),
        .quad(cnt_quad), .count(count), .cnt_zero(cnt_zero)
    );

    qspinor_shifter u_shift (
        .clk(clk), .rstn(rstn), .cmd(cmd), .read_addr(read_addr), .read_acc(read_acc),
        .quad_en(quad_en), .count(count), .sample(sample), .state(state),
        .lanes_in(lanes_in), .lanes_out(lanes_out), .rx_word(rx_word)
    );

    for (genvar i = 0; i < `QSPINOR_LANES; i++) begin : g_pad
        assign qspi_data[i] = dir[i] ? lanes_out[i] : 1'bz;
    end

    assign lanes_in = qspi_data;

endmodule

// File: dv/spi_flash_model.sv
`timescale 1ns/1ps

module spi_flash_model (
    input  logic        csb,
    input  logic        sck,
    input  logic        quad,     // 4-4-4 when set, else 1-1-1
    input  logic [3:0]  dummy,
    input  logic [7:0]  exp_cmd,
    input  logic [23:0] exp_addr,
    inout  wire  [3:0]  data,
    output int          cmd_errs,
    output int          addr_errs
);
    logic [31:0] frame;
    logic [23:0] a;
    logic [7:0]  dbyte;
    logic [3:0]  dout;
    logic [3:0]  oe;
    int          nbit;

    // pads released as soon as csb rises
    for (genvar i = 0; i < 4; i++) begin : g_io
        assign data[i] = (!csb && oe[i]) ? dout[i] : 1'bz;
    end

    initial begin
        cmd_errs  = 0;
        addr_errs = 0;
        oe        = '0;
        dout      = '0;
    end

    always begin
        @(negedge csb);
        oe    = '0;
        frame = '0;
        repeat (quad ? 8 : 32) begin
            @(posedge sck);
            frame = quad ? {frame[27:0], data} : {frame[30:0], data[0]};
        end
        if (frame[31:24] !== exp_cmd) begin
            cmd_errs++;
            $display("error at %0t ns: flash model got command %h, expected %h",
                     $time, frame[31:24], exp_cmd);
        end
        if (frame[23:0] !== exp_addr) begin
            addr_errs++;
            $display("error at %0t ns: flash model got address %h, expected %h",
                     $time, frame[23:0], exp_addr);
        end
        repeat (dummy) @(posedge sck);
        a    = frame[23:0];
        nbit = 7;
        // one bit or nibble per falling sck with msb first
        while (csb === 1'b0) begin
            @(negedge sck or posedge csb);
            if (csb === 1'b0) begin
                dbyte = a * 8'd7 + 8'h1d;
                if (quad) begin
                    dout = dbyte[nbit -: 4];
                    oe   = 4'hf;
                    nbit = nbit - 4;
                end else begin
                    dout = {2'b00, dbyte[nbit], 1'b0};  // io1 carries data
                    oe   = 4'b0010;
                    nbit = nbit - 1;
                end
                if (nbit < 0) begin
                    nbit = 7;
                    a    = a + 1;
                end
            end
        end
    end

endmodule

// File: dv/tb_qspinor.sv
`timescale 1ns/1ps
`include "qspinor_params.svh"

module tb_qspinor;

    localparam int TIMEOUT_CYC = 60 * 200 + 1000;

    logic                       clk;
    logic                       rstn;
    logic                       req;
    logic                       wr_b;
    logic                       ctrl_sel;
    qspinor_bus_pkg::acc_t      acc;
    qspinor_bus_pkg::bus_addr_t addr;
    qspinor_bus_pkg::bus_data_t wdata;
    logic                       resp;
    qspinor_bus_pkg::bus_data_t rdata;
    logic                       fault;
    logic                       qspi_sck;
    logic                       qspi_csb;
    wire  [3:0]                 qspi_data;

    logic        m_quad;
    logic [3:0]  m_dummy;
    logic [7:0]  m_cmd;
    logic [23:0] m_addr;
    int          cmd_errs;
    int          addr_errs;

    logic [31:0]                exp_data;
    logic                       cmp_data;
    int                         resp_cnt;
    int                         resp_exp;
    int                         errors;
    int                         checks;
    int                         cycles;
    int                         seed;
    logic [3:0]                 d;
    qspinor_bus_pkg::bus_addr_t a;

    qspinor_top UUT (
        .clk(clk), .rstn(rstn), .req(req), .wr_b(wr_b), .ctrl_sel(ctrl_sel),
        .acc(acc), .addr(addr), .wdata(wdata), .resp(resp), .rdata(rdata),
        .fault(fault), .qspi_sck(qspi_sck), .qspi_csb(qspi_csb), .qspi_data(qspi_data)
    );

    spi_flash_model u_flash (
        .csb(qspi_csb), .sck(qspi_sck), .quad(m_quad), .dummy(m_dummy),
        .exp_cmd(m_cmd), .exp_addr(m_addr), .data(qspi_data), .cmd_errs(cmd_errs),
        .addr_errs(addr_errs)
    );

    assign (weak0, weak1) qspi_data = 4'hf;  // pull-up on idle lines

    always #10 clk = ~clk;

    // expected word from the flash byte rule with zero upper bytes for short reads
    function automatic logic [31:0] ref_read(input logic [23:0] base,
                                             input qspinor_bus_pkg::acc_t sz);
        logic [31:0] w;
        logic [23:0] p;
        int          n;
        int          i;
        w = '0;
        n = (sz == qspinor_bus_pkg::ACC_1B) ? 1 : (sz == qspinor_bus_pkg::ACC_2B) ? 2 : 4;
        for (i = 0; i < n; i++) begin
            p = (base + i) * 7 + 24'h1d;
            w[8*i +: 8] = p[7:0];
        end
        return w;
    endfunction

    function automatic logic [31:0] cfg_value(input logic q, input logic [3:0] dc,
                                              input logic [7:0] c);
        logic [31:0] w;
        w = '0;
        w[`CFG_QUAD_BIT]                 = q;
        w[`CFG_DUMMY_MSB:`CFG_DUMMY_LSB] = dc;
        w[`CFG_CMD_MSB:`CFG_CMD_LSB]     = c;
        return w;
    endfunction

    function automatic qspinor_bus_pkg::acc_t rand_size();
        case ($urandom % 3)
            0: return qspinor_bus_pkg::ACC_1B;
            1: return qspinor_bus_pkg::ACC_2B;
            default: return qspinor_bus_pkg::ACC_4B;
        endcase
    endfunction

    // one req pulse with fault checked in the req cycle
    task automatic issue(input logic wr, input logic sel, input qspinor_bus_pkg::acc_t sz,
                         input logic [23:0] ad, input logic [31:0] wd, input logic exp_fault);
        @(posedge clk);
        req      <= 1'b1;
        wr_b     <= wr;
        ctrl_sel <= sel;
        acc      <= sz;
        addr     <= ad;
        wdata    <= wd;
        @(posedge clk);
        req <= 1'b0;
        checks++;
        if (fault !== exp_fault) begin
            errors++;
            $display("error at %0t ns: fault %b, expected %b", $time, fault, exp_fault);
        end
    endtask

    task automatic expect_resp(input logic [31:0] dv, input logic cmp);
        exp_data = dv;
        cmp_data = cmp;
        resp_exp++;
    endtask

    task automatic wait_resp();
        while (resp_cnt != resp_exp) @(posedge clk);
    endtask

    // register answers come in the cycle right after req
    task automatic wait_reg_resp();
        @(posedge clk);
        checks++;
        if (resp !== 1'b1) begin
            errors++;
            $display("error at %0t ns: resp %b one cycle after req, expected 1", $time, resp);
        end
        wait_resp();
    endtask

    task automatic reg_read(input qspinor_bus_pkg::reg_ofs_t ofs,
                            input qspinor_bus_pkg::acc_t sz, input logic [31:0] dv);
        expect_resp(dv, 1'b1);
        issue(1'b0, 1'b1, sz, {21'd0, ofs}, '0, 1'b0);
        wait_reg_resp();
    endtask

    task automatic cfg_write(input logic [31:0] wd);
        expect_resp('0, 1'b0);
        issue(1'b1, 1'b1, qspinor_bus_pkg::ACC_2B, {21'd0, `REG_CFG_OFS}, wd, 1'b0);
        wait_reg_resp();
    endtask

    task automatic flash_read(input logic [23:0] ad, input qspinor_bus_pkg::acc_t sz);
        m_addr = ad;
        expect_resp(ref_read(ad, sz), 1'b1);
        issue(1'b0, 1'b0, sz, ad, '0, 1'b0);
        wait_resp();
    endtask

    // compares every response against the pending expectation
    always @(posedge clk) begin
        if (rstn && resp) begin
            if (resp_cnt >= resp_exp) begin
                errors++;
                $display("unexpected response at %0t ns", $time);
            end else begin
                checks++;
                if (cmp_data && rdata !== exp_data) begin
                    errors++;
                    $display("error at %0t ns: rdata %h, expected %h", $time, rdata, exp_data);
                end
                if (qspi_csb !== 1'b1) begin
                    errors++;
                    $display("error at %0t ns: csb still low at resp", $time);
                end
                resp_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYC) begin
            $display("timeout after %0d cycles, a response never came", cycles);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        seed     = $urandom(32'h49e6);
        clk      = 1'b0;
        rstn     = 1'b0;
        req      = 1'b0;
        wr_b     = 1'b0;
        ctrl_sel = 1'b0;
        acc      = qspinor_bus_pkg::ACC_1B;
        addr     = '0;
        wdata    = '0;
        m_quad   = 1'b0;
        m_dummy  = '0;
        m_cmd    = `CMD_RESET_VAL;
        m_addr   = '0;
        resp_cnt = 0;
        resp_exp = 0;
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;

        reg_read(`REG_STAT_OFS, qspinor_bus_pkg::ACC_1B, 32'h0);  // not busy
        reg_read(`REG_CFG_OFS, qspinor_bus_pkg::ACC_2B, cfg_value(1'b0, 4'd0, `CMD_RESET_VAL));

        cfg_write(cfg_value(1'b1, 4'd9, 8'ha5));
        reg_read(`REG_CFG_OFS, qspinor_bus_pkg::ACC_2B, cfg_value(1'b1, 4'd9, 8'ha5));

        // single line reads
        cfg_write(cfg_value(1'b0, 4'd0, 8'h03));
        repeat (20) begin
            a = $urandom;
            flash_read(a, rand_size());
        end

        // quad reads with dummy 1..15
        m_quad = 1'b1;
        m_cmd  = 8'heb;
        repeat (20) begin
            d = 1 + $urandom % 15;
            cfg_write(cfg_value(1'b1, d, 8'heb));
            m_dummy = d;
            a = $urandom;
            flash_read(a, rand_size());
        end

        // illegal requests get no resp and leave the config untouched
        issue(1'b1, 1'b0, qspinor_bus_pkg::ACC_4B, 24'h000100, 32'h1234, 1'b1);
        issue(1'b1, 1'b1, qspinor_bus_pkg::ACC_1B, {21'd0, `REG_STAT_OFS}, 32'h80, 1'b1);
        issue(1'b0, 1'b1, qspinor_bus_pkg::ACC_4B, {21'd0, `REG_CFG_OFS}, '0, 1'b1);
        issue(1'b1, 1'b1, qspinor_bus_pkg::ACC_1B, {21'd0, `REG_CFG_OFS},
              cfg_value(1'b0, 4'd3, 8'h3b), 1'b1);
        issue(1'b0, 1'b1, qspinor_bus_pkg::ACC_1B, 24'd3, '0, 1'b1);
        repeat (3) @(posedge clk);
        reg_read(`REG_CFG_OFS, qspinor_bus_pkg::ACC_2B, cfg_value(1'b1, d, 8'heb));

        // request while a read is in flight
        a = $urandom;
        m_addr = a;
        expect_resp(ref_read(a, qspinor_bus_pkg::ACC_4B), 1'b1);
        issue(1'b0, 1'b0, qspinor_bus_pkg::ACC_4B, a, '0, 1'b0);
        repeat (6) @(posedge clk);
        issue(1'b0, 1'b1, qspinor_bus_pkg::ACC_2B, {21'd0, `REG_CFG_OFS}, '0, 1'b1);
        wait_resp();
        repeat (4) @(posedge clk);

        if (cmd_errs != 0) begin
            errors += cmd_errs;
            $display("flash model saw %0d wrong read commands", cmd_errs);
        end
        if (addr_errs != 0) begin
            errors += addr_errs;
            $display("flash model saw %0d wrong read addresses", addr_errs);
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+hw
hw/qspinor_bus_pkg.sv
hw/qspinor_flash_pkg.sv
hw/qspinor_regs.sv
hw/qspinor_read_fsm.sv
hw/qspinor_bit_counter.sv
hw/qspinor_shifter.sv
hw/qspinor_top.sv
dv/spi_flash_model.sv
dv/tb_qspinor.sv

// File: Bender.yml
package:
  name: qspinor

sources:
  - include_dirs:
      - hw
    files:
      - hw/qspinor_bus_pkg.sv
      - hw/qspinor_flash_pkg.sv
      - hw/qspinor_regs.sv
      - hw/qspinor_read_fsm.sv
      - hw/qspinor_bit_counter.sv
      - hw/qspinor_shifter.sv
      - hw/qspinor_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/spi_flash_model.sv
      - dv/tb_qspinor.sv
